//--- rtl/keccak_pkg.sv
// --------------------
// Keccak shared definitions
// State views, modes, step codes, rate and suffix constants
// --------------------
`default_nettype none

package keccak_pkg;

    // One 64-bit lane, also the stream data word
    typedef logic [63:0] lane_t;
    typedef logic [7:0]  keep_t;
    typedef logic [7:0]  byte_cnt_t;

    // 1600-bit state, seen as 25 lanes (index x + 5y) or as 200 bytes in FIPS order
    typedef union packed {
        lane_t [24:0]      lanes;
        logic [199:0][7:0] bytes;
    } keccak_state_u;

    typedef enum logic {
        MODE_SHA3_256,
        MODE_SHAKE128
    } keccak_mode_e;

    typedef enum logic [2:0] {
        STEP_THETA,
        STEP_RHO,
        STEP_PI,
        STEP_CHI,
        STEP_IOTA
    } step_e;

    localparam byte_cnt_t   RATE_BYTES_SHA3_256   = 8'd136;
    localparam byte_cnt_t   RATE_BYTES_SHAKE128   = 8'd168;
    localparam logic [7:0]  SUFFIX_SHA3           = 8'h06;
    localparam logic [7:0]  SUFFIX_SHAKE          = 8'h1F;
    localparam byte_cnt_t   DIGEST_BYTES_SHA3_256 = 8'd32;
    localparam int          NUM_ROUNDS            = 24;

    // Iota constants, one per round
    function automatic lane_t round_const(input logic [4:0] idx);
        case (idx)
            5'd0:    return 64'h0000_0000_0000_0001;
            5'd1:    return 64'h0000_0000_0000_8082;
            5'd2:    return 64'h8000_0000_0000_808A;
            5'd3:    return 64'h8000_0000_8000_8000;
            5'd4:    return 64'h0000_0000_0000_808B;
            5'd5:    return 64'h0000_0000_8000_0001;
            5'd6:    return 64'h8000_0000_8000_8081;
            5'd7:    return 64'h8000_0000_0000_8009;
            5'd8:    return 64'h0000_0000_0000_008A;
            5'd9:    return 64'h0000_0000_0000_0088;
            5'd10:   return 64'h0000_0000_8000_8009;
            5'd11:   return 64'h0000_0000_8000_000A;
            5'd12:   return 64'h0000_0000_8000_808B;
            5'd13:   return 64'h8000_0000_0000_008B;
            5'd14:   return 64'h8000_0000_0000_8089;
            5'd15:   return 64'h8000_0000_0000_8003;
            5'd16:   return 64'h8000_0000_0000_8002;
            5'd17:   return 64'h8000_0000_0000_0080;
            5'd18:   return 64'h0000_0000_0000_800A;
            5'd19:   return 64'h8000_0000_8000_000A;
            5'd20:   return 64'h8000_0000_8000_8081;
            5'd21:   return 64'h8000_0000_0000_8080;
            5'd22:   return 64'h0000_0000_8000_0001;
            5'd23:   return 64'h8000_0000_8000_8008;
            default: return '0;
        endcase
    endfunction

    function automatic byte_cnt_t rate_bytes(input keccak_mode_e mode);
        return (mode == MODE_SHA3_256) ? RATE_BYTES_SHA3_256 : RATE_BYTES_SHAKE128;
    endfunction

endpackage

`default_nettype wire

//--- rtl/keccak_step.sv
// --------------------
// Keccak step mapping
// One of theta, rho, pi, chi or iota on the lane view
// --------------------
`timescale 1ns/1ps
`default_nettype none

module keccak_step import keccak_pkg::*; (
    input  keccak_state_u state_i,
    input  step_e         step_i,
    input  wire [4:0]     round_i,
    output keccak_state_u state_o
);

    // Rho rotation offsets, indexed x + 5y
    localparam int RHO_OFF [25] = '{
         0,  1, 62, 28, 27,
        36, 44,  6, 55, 20,
         3, 10, 43, 25, 39,
        41, 45, 15, 21,  8,
        18,  2, 61, 56, 14
    };

    lane_t col_par [5];
    lane_t theta_d [5];

    function automatic lane_t rol(input lane_t a, input int n);
        // A shift of 64 yields zero, so n = 0 passes the lane through
        return (a << n) | (a >> (64 - n));
    endfunction

    // --------------------
    // Theta column parity
    // --------------------
    always_comb begin
        for (int x = 0; x < 5; x++) begin
            col_par[x] = state_i.lanes[x] ^ state_i.lanes[x + 5] ^ state_i.lanes[x + 10]
                       ^ state_i.lanes[x + 15] ^ state_i.lanes[x + 20];
        end
    end

    // D[x] = C[x-1] ^ rot(C[x+1], 1)
    always_comb begin
        for (int x = 0; x < 5; x++) begin
            theta_d[x] = col_par[(x + 4) % 5] ^ rol(col_par[(x + 1) % 5], 1);
        end
    end

    // --------------------
    // Step select
    // --------------------
    always_comb begin
        state_o = state_i;
        case (step_i)
            STEP_THETA: begin
                for (int i = 0; i < 25; i++) begin
                    state_o.lanes[i] = state_i.lanes[i] ^ theta_d[i % 5];
                end
            end
            STEP_RHO: begin
                for (int i = 0; i < 25; i++) begin
                    state_o.lanes[i] = rol(state_i.lanes[i], RHO_OFF[i]);
                end
            end
            STEP_PI: begin
                // A'[x,y] = A[(x + 3y) mod 5, x]
                for (int x = 0; x < 5; x++) begin
                    for (int y = 0; y < 5; y++) begin
                        state_o.lanes[x + 5*y] = state_i.lanes[(x + 3*y) % 5 + 5*x];
                    end
                end
            end
            STEP_CHI: begin
                // Nonlinear row mixing
                for (int x = 0; x < 5; x++) begin
                    for (int y = 0; y < 5; y++) begin
                        state_o.lanes[x + 5*y] = state_i.lanes[x + 5*y]
                            ^ (~state_i.lanes[(x + 1) % 5 + 5*y]
                               & state_i.lanes[(x + 2) % 5 + 5*y]);
                    end
                end
            end
            STEP_IOTA: begin
                // Only lane (0,0) takes the round constant
                state_o.lanes[0] = state_i.lanes[0] ^ round_const(round_i);
            end
            default: state_o = state_i;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/keccak_absorb.sv
// --------------------
// Keccak absorb stage
// XORs input beats into the rate bytes of the state
// and applies the 10*1 padding with the domain suffix
// --------------------
`timescale 1ns/1ps
`default_nettype none

module keccak_absorb import keccak_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst,
    input  keccak_state_u      state_i,
    input  keccak_mode_e       mode_i,
    input  wire logic          absorbing_i,
    input  wire logic          pad_en_i,
    input  wire logic          blk_clear_i,
    // Sink stream
    input  lane_t              t_data_i,
    input  keep_t              t_keep_i,
    input  wire logic          t_last_i,
    input  wire logic          t_valid_i,
    output logic               t_ready_o,
    // To sponge
    output logic               absorb_we_o,
    output keccak_state_u      absorb_state_o,
    output logic               block_full_o,
    output logic               msg_done_o
);

    byte_cnt_t  byte_cnt_q;
    byte_cnt_t  rate;
    byte_cnt_t  beat_bytes;
    logic [7:0] suffix;
    logic       beat_ok;

    assign rate       = rate_bytes(mode_i);
    assign suffix     = (mode_i == MODE_SHA3_256) ? SUFFIX_SHA3 : SUFFIX_SHAKE;
    // Keep is packed from byte 0, so its popcount is the byte count
    assign beat_bytes = byte_cnt_t'($countones(t_keep_i));

    assign block_full_o = (byte_cnt_q == rate);
    assign t_ready_o    = absorbing_i && !block_full_o && !msg_done_o;
    assign beat_ok      = t_valid_i && t_ready_o;
    assign absorb_we_o  = beat_ok || pad_en_i;

    // --------------------
    // Next state value
    // --------------------
    always_comb begin
        absorb_state_o = state_i;
        if (pad_en_i) begin
            // Suffix and final 0x80 may fall on the same byte, the XORs stack
            absorb_state_o.bytes[byte_cnt_q] = state_i.bytes[byte_cnt_q] ^ suffix;
            absorb_state_o.bytes[rate - 8'd1] = absorb_state_o.bytes[rate - 8'd1] ^ 8'h80;
        end else begin
            for (int i = 0; i < 8; i++) begin
                if (t_keep_i[i]) begin
                    absorb_state_o.bytes[byte_cnt_q + i] =
                        state_i.bytes[byte_cnt_q + i] ^ t_data_i[8*i +: 8];
                end
            end
        end
    end

    // Byte count and message-done flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byte_cnt_q <= '0;
            msg_done_o <= 1'b0;
        end else begin
            if (blk_clear_i) begin
                byte_cnt_q <= '0;
            end else if (beat_ok) begin
                byte_cnt_q <= byte_cnt_q + beat_bytes;
            end
            // Flag is consumed by the padding cycle
            if (pad_en_i) begin
                msg_done_o <= 1'b0;
            end else if (beat_ok && t_last_i) begin
                msg_done_o <= 1'b1;
            end
        end
    end

    // Rate block never overfills
    a_cnt_in_rate: assert property (@(posedge clk) disable iff (rst)
        byte_cnt_q <= rate)
        else $error("absorb byte count above rate");

endmodule

`default_nettype wire

//--- rtl/keccak_sponge.sv
// --------------------
// Keccak sponge control
// State register, phase FSM and round counter
// --------------------
`timescale 1ns/1ps
`default_nettype none

module keccak_sponge import keccak_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     start_i,
    input  keccak_mode_e  mode_i,
    input  wire logic     stop_i,
    // From absorb
    input  wire logic     absorb_we_i,
    input  keccak_state_u absorb_state_i,
    input  wire logic     block_full_i,
    input  wire logic     msg_done_i,
    // From squeeze
    input  wire logic     beat_taken_i,
    input  wire logic     block_empty_i,
    input  wire logic     squeeze_done_i,
    // Shared state and control
    output keccak_state_u state_o,
    output keccak_mode_e  mode_o,
    output logic          absorbing_o,
    output logic          pad_en_o,
    output logic          squeezing_o,
    output logic          blk_clear_o
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_ABSORB,
        S_PAD,
        S_THETA,
        S_RHO,
        S_PI,
        S_CHI,
        S_IOTA,
        S_SQUEEZE
    } fsm_e;

    fsm_e          state, state_nx;
    keccak_state_u step_out;
    step_e         step_sel;
    logic [4:0]    round_q;
    logic          padded_q;
    logic          permuting;
    logic          last_round;
    logic          start_ok;

    assign permuting  = state inside {S_THETA, S_RHO, S_PI, S_CHI, S_IOTA};
    assign last_round = (round_q == 5'(NUM_ROUNDS - 1));
    assign start_ok   = (state == S_IDLE) && start_i;

    // Step unit works on the live state, one mapping per cycle
    always_comb begin
        case (state)
            S_RHO:   step_sel = STEP_RHO;
            S_PI:    step_sel = STEP_PI;
            S_CHI:   step_sel = STEP_CHI;
            S_IOTA:  step_sel = STEP_IOTA;
            default: step_sel = STEP_THETA;
        endcase
    end

    keccak_step u_step (
        .state_i (state_o),
        .step_i  (step_sel),
        .round_i (round_q),
        .state_o (step_out)
    );

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        state_nx = state;
        case (state)
            S_IDLE: begin
                if (start_i) state_nx = S_ABSORB;
            end
            S_ABSORB: begin
                // A full block is permuted first, even after the last beat
                if (block_full_i) begin
                    state_nx = S_THETA;
                end else if (msg_done_i) begin
                    state_nx = S_PAD;
                end
            end
            S_PAD:   state_nx = S_THETA;
            S_THETA: state_nx = S_RHO;
            S_RHO:   state_nx = S_PI;
            S_PI:    state_nx = S_CHI;
            S_CHI:   state_nx = S_IOTA;
            S_IOTA: begin
                if (!last_round) begin
                    state_nx = S_THETA;
                end else begin
                    state_nx = padded_q ? S_SQUEEZE : S_ABSORB;
                end
            end
            S_SQUEEZE: begin
                if (stop_i || squeeze_done_i) begin
                    state_nx = S_IDLE;
                end else if (beat_taken_i && block_empty_i) begin
                    state_nx = S_THETA;
                end
            end
            default: state_nx = S_IDLE;
        endcase
    end

    assign absorbing_o = (state == S_ABSORB);
    assign pad_en_o    = (state == S_PAD);
    // Output stalls in the cycle that stop is seen
    assign squeezing_o = (state == S_SQUEEZE) && !stop_i;
    // Counters restart at every new message and with every permutation
    assign blk_clear_o = start_ok
                      || (absorbing_o && block_full_i)
                      || pad_en_o
                      || (squeezing_o && beat_taken_i && block_empty_i);

    // Control registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            round_q  <= '0;
            padded_q <= 1'b0;
            mode_o   <= MODE_SHA3_256;
        end else begin
            state <= state_nx;
            if (start_ok) begin
                mode_o   <= mode_i;
                padded_q <= 1'b0;
            end else if (pad_en_o) begin
                padded_q <= 1'b1;
            end
            if (state == S_IOTA) begin
                round_q <= last_round ? 5'd0 : round_q + 5'd1;
            end
        end
    end

    // 1600-bit state
    always_ff @(posedge clk) begin
        if (start_ok) begin
            state_o <= '0;
        end else if (permuting) begin
            state_o <= step_out;
        end else if (absorb_we_i) begin
            state_o <= absorb_state_i;
        end
    end

    a_mode_stable: assert property (@(posedge clk) disable iff (rst)
        state != S_IDLE |=> $stable(mode_o))
        else $error("mode changed while core busy");

    a_state_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(state))
        else $error("sponge FSM state unknown");

endmodule

`default_nettype wire

//--- rtl/keccak_squeeze.sv
// --------------------
// Keccak squeeze stage
// Serves rate bytes of the state as 64-bit output beats
// --------------------
`timescale 1ns/1ps
`default_nettype none

module keccak_squeeze import keccak_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  keccak_state_u state_i,
    input  keccak_mode_e  mode_i,
    input  wire logic     squeezing_i,
    input  wire logic     blk_clear_i,
    // Source stream
    input  wire logic     t_ready_i,
    output lane_t         t_data_o,
    output keep_t         t_keep_o,
    output logic          t_last_o,
    output logic          t_valid_o,
    // To sponge
    output logic          beat_taken_o,
    output logic          block_empty_o,
    output logic          squeeze_done_o
);

    byte_cnt_t blk_cnt_q;
    byte_cnt_t total_q;
    byte_cnt_t rate;

    assign rate = rate_bytes(mode_i);

    // Eight bytes at the block count, in FIPS byte order
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            t_data_o[8*i +: 8] = state_i.bytes[blk_cnt_q + i];
        end
    end

    // Both rates are whole lanes, so every beat is full
    assign t_valid_o    = squeezing_i;
    assign t_keep_o     = {8{squeezing_i}};
    assign beat_taken_o = t_valid_o && t_ready_i;

    // Digest end and rate end, both seen on the beat that reaches them
    assign t_last_o       = squeezing_i && (mode_i == MODE_SHA3_256)
                         && (total_q + 8'd8 == DIGEST_BYTES_SHA3_256);
    assign squeeze_done_o = beat_taken_o && t_last_o;
    assign block_empty_o  = (mode_i == MODE_SHAKE128) && (blk_cnt_q + 8'd8 == rate);

    // --------------------
    // Byte counters
    // --------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blk_cnt_q <= '0;
            total_q   <= '0;
        end else begin
            if (blk_clear_i) begin
                blk_cnt_q <= '0;
            end else if (beat_taken_o) begin
                blk_cnt_q <= blk_cnt_q + 8'd8;
            end
            // Clear from outside squeeze means a new message
            // SHAKE output may wrap this count, only SHA3 reads it
            if (blk_clear_i && !squeezing_i) begin
                total_q <= '0;
            end else if (beat_taken_o) begin
                total_q <= total_q + 8'd8;
            end
        end
    end

    a_cnt_in_rate: assert property (@(posedge clk) disable iff (rst)
        blk_cnt_q <= rate)
        else $error("squeeze byte count above rate");

endmodule

`default_nettype wire

//--- rtl/keccak_top.sv
// --------------------
// Keccak sponge core top
// Absorb, sponge and squeeze wired together
// --------------------
`timescale 1ns/1ps
`default_nettype none

module keccak_top import keccak_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    start_i,
    input  keccak_mode_e mode_i,
    input  wire logic    stop_i,
    // Sink stream
    input  lane_t        t_data_i,
    input  keep_t        t_keep_i,
    input  wire logic    t_last_i,
    input  wire logic    t_valid_i,
    output logic         t_ready_o,
    // Source stream
    output lane_t        t_data_o,
    output keep_t        t_keep_o,
    output logic         t_last_o,
    output logic         t_valid_o,
    input  wire logic    t_ready_i
);

    keccak_state_u state;
    keccak_state_u absorb_state;
    keccak_mode_e  mode;
    logic          absorb_we;
    logic          block_full;
    logic          msg_done;
    logic          absorbing;
    logic          pad_en;
    logic          squeezing;
    logic          blk_clear;
    logic          beat_taken;
    logic          block_empty;
    logic          squeeze_done;

    // Producer
    keccak_absorb u_absorb (
        .clk            (clk),
        .rst            (rst),
        .state_i        (state),
        .mode_i         (mode),
        .absorbing_i    (absorbing),
        .pad_en_i       (pad_en),
        .blk_clear_i    (blk_clear),
        .t_data_i       (t_data_i),
        .t_keep_i       (t_keep_i),
        .t_last_i       (t_last_i),
        .t_valid_i      (t_valid_i),
        .t_ready_o      (t_ready_o),
        .absorb_we_o    (absorb_we),
        .absorb_state_o (absorb_state),
        .block_full_o   (block_full),
        .msg_done_o     (msg_done)
    );

    // State and permutation
    keccak_sponge u_sponge (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start_i),
        .mode_i         (mode_i),
        .stop_i         (stop_i),
        .absorb_we_i    (absorb_we),
        .absorb_state_i (absorb_state),
        .block_full_i   (block_full),
        .msg_done_i     (msg_done),
        .beat_taken_i   (beat_taken),
        .block_empty_i  (block_empty),
        .squeeze_done_i (squeeze_done),
        .state_o        (state),
        .mode_o         (mode),
        .absorbing_o    (absorbing),
        .pad_en_o       (pad_en),
        .squeezing_o    (squeezing),
        .blk_clear_o    (blk_clear)
    );

    // Consumer
    keccak_squeeze u_squeeze (
        .clk            (clk),
        .rst            (rst),
        .state_i        (state),
        .mode_i         (mode),
        .squeezing_i    (squeezing),
        .blk_clear_i    (blk_clear),
        .t_ready_i      (t_ready_i),
        .t_data_o       (t_data_o),
        .t_keep_o       (t_keep_o),
        .t_last_o       (t_last_o),
        .t_valid_o      (t_valid_o),
        .beat_taken_o   (beat_taken),
        .block_empty_o  (block_empty),
        .squeeze_done_o (squeeze_done)
    );

endmodule

`default_nettype wire

//--- include/keccak_ref_model.svh
// --------------------
// Keccak reference model
// Software Keccak-f[1600] and padded sponge for expected outputs
// --------------------
`ifndef KECCAK_REF_MODEL_SVH
`define KECCAK_REF_MODEL_SVH

// Message bytes in, expected output bytes out
logic [7:0]  msg_q [$];
logic [7:0]  exp_q [$];
// Model state as 25 lanes, index x + 5y
logic [63:0] ref_st [25];

function automatic logic [63:0] rotl64(input logic [63:0] a, input int n);
    int s;
    s = n % 64;
    if (s == 0) begin
        return a;
    end
    return (a << s) | (a >> (64 - s));
endfunction

// rc(t) from the 8-bit LFSR with taps 0, 4, 5, 6
function automatic logic lfsr_bit(input int t);
    logic [7:0] r;
    r = 8'h01;
    for (int i = 0; i < t % 255; i++) begin
        r = {r[6:0], 1'b0} ^ (r[7] ? 8'h71 : 8'h00);
    end
    return r[0];
endfunction

// Round constant bits sit at positions 2^j - 1
function automatic logic [63:0] iota_const(input int ir);
    logic [63:0] rc;
    rc = '0;
    for (int j = 0; j < 7; j++) begin
        rc[(1 << j) - 1] = lfsr_bit(j + 7 * ir);
    end
    return rc;
endfunction

task automatic permute_model();
    logic [63:0] c [5];
    logic [63:0] b [25];
    int x;
    int y;
    int nx;
    for (int ir = 0; ir < 24; ir++) begin
        // Theta
        for (int i = 0; i < 5; i++) begin
            c[i] = ref_st[i] ^ ref_st[i + 5] ^ ref_st[i + 10] ^ ref_st[i + 15] ^ ref_st[i + 20];
        end
        for (int i = 0; i < 25; i++) begin
            ref_st[i] = ref_st[i] ^ c[(i + 4) % 5] ^ rotl64(c[(i + 1) % 5], 1);
        end
        // Rho by walking (x, y) -> (y, 2x + 3y) from (1, 0)
        x = 1;
        y = 0;
        for (int t = 0; t < 24; t++) begin
            ref_st[x + 5 * y] = rotl64(ref_st[x + 5 * y], ((t + 1) * (t + 2) / 2) % 64);
            nx = y;
            y = (2 * x + 3 * y) % 5;
            x = nx;
        end
        // Pi as B[y, 2x + 3y] = A[x, y]
        for (x = 0; x < 5; x++) begin
            for (y = 0; y < 5; y++) begin
                b[y + 5 * ((2 * x + 3 * y) % 5)] = ref_st[x + 5 * y];
            end
        end
        // Chi then iota
        for (x = 0; x < 5; x++) begin
            for (y = 0; y < 5; y++) begin
                ref_st[x + 5 * y] = b[x + 5 * y]
                    ^ (~b[(x + 1) % 5 + 5 * y] & b[(x + 2) % 5 + 5 * y]);
            end
        end
        ref_st[0] = ref_st[0] ^ iota_const(ir);
    end
endtask

// Pad msg_q with suffix and final 0x80, absorb, squeeze out_len bytes
task automatic sponge_model(input int rate, input logic [7:0] suffix, input int out_len);
    logic [7:0] blk [$];
    int pos;
    blk = msg_q;
    blk.push_back(suffix);
    while (blk.size() % rate != 0) begin
        blk.push_back(8'h00);
    end
    blk[blk.size() - 1] = blk[blk.size() - 1] ^ 8'h80;
    for (int i = 0; i < 25; i++) begin
        ref_st[i] = '0;
    end
    for (int base = 0; base < blk.size(); base += rate) begin
        for (int i = 0; i < rate; i++) begin
            ref_st[i / 8][8 * (i % 8) +: 8] = ref_st[i / 8][8 * (i % 8) +: 8] ^ blk[base + i];
        end
        permute_model();
    end
    exp_q.delete();
    pos = 0;
    while (exp_q.size() < out_len) begin
        if (pos == rate) begin
            permute_model();
            pos = 0;
        end
        exp_q.push_back(ref_st[pos / 8][8 * (pos % 8) +: 8]);
        pos++;
    end
endtask

`endif

//--- test/tb_keccak.sv
// --------------------
// Keccak core testbench
// Directed SHA3-256 and SHAKE128 runs checked against a software model
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tb_keccak import keccak_pkg::*;;

    localparam int WAIT_LIMIT = 1000;

    logic         clk;
    logic         rst;
    logic         start_i;
    keccak_mode_e mode_i;
    logic         stop_i;
    lane_t        t_data_i;
    keep_t        t_keep_i;
    logic         t_last_i;
    logic         t_valid_i;
    logic         t_ready_o;
    lane_t        t_data_o;
    keep_t        t_keep_o;
    logic         t_last_o;
    logic         t_valid_o;
    logic         t_ready_i;

    int errors;
    int checks;
    bit aborted;

    `include "keccak_ref_model.svh"

    keccak_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .start_i   (start_i),
        .mode_i    (mode_i),
        .stop_i    (stop_i),
        .t_data_i  (t_data_i),
        .t_keep_i  (t_keep_i),
        .t_last_i  (t_last_i),
        .t_valid_i (t_valid_i),
        .t_ready_o (t_ready_o),
        .t_data_o  (t_data_o),
        .t_keep_o  (t_keep_o),
        .t_last_o  (t_last_o),
        .t_valid_o (t_valid_o),
        .t_ready_i (t_ready_i)
    );

    always #5 clk = ~clk;

    // --------------------
    // Stream helpers
    // --------------------
    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        assert (actual === expected)
            else begin
                errors++;
                $display("error %0t %s got %h expected %h", $time, name, actual, expected);
            end
    endtask

    // Start pulse while the core is idle
    task automatic start_message(input keccak_mode_e mode);
        mode_i  = mode;
        start_i = 1'b1;
        @(posedge clk);
        #1;
        start_i = 1'b0;
    endtask

    // Beats of msg_q, bytes packed from lane byte 0
    task automatic send_message(input bit gaps);
        int idx;
        int n;
        int waited;
        bit done;
        idx = 0;
        do begin
            n = (msg_q.size() - idx > 8) ? 8 : msg_q.size() - idx;
            t_data_i = '0;
            t_keep_i = '0;
            for (int k = 0; k < n; k++) begin
                t_data_i[8 * k +: 8] = msg_q[idx + k];
                t_keep_i[k] = 1'b1;
            end
            t_last_i  = (idx + n == msg_q.size());
            t_valid_i = !gaps || ($urandom % 4 != 0);
            done   = 1'b0;
            waited = 0;
            while (!done && !aborted) begin
                @(negedge clk);
                done = t_valid_i && t_ready_o;
                @(posedge clk);
                #1;
                // Once raised, valid stays up until the beat is taken
                if (!done && !t_valid_i) begin
                    t_valid_i = ($urandom % 4 != 0);
                end
                waited++;
                if (!done && waited > WAIT_LIMIT) begin
                    $display("timeout at %0t, input beat %0d was never accepted", $time, idx / 8);
                    errors++;
                    aborted = 1'b1;
                end
            end
            idx += n;
        end while (idx < msg_q.size() && !aborted);
        t_valid_i = 1'b0;
        t_last_i  = 1'b0;
        t_keep_i  = '0;
        t_data_i  = '0;
    endtask

    // Take nbeats output beats and compare them with exp_q
    task automatic collect_output(input int nbeats, input bit stall, input bit sha3);
        int    got;
        int    idle_cycles;
        bit    held;
        lane_t held_data;
        lane_t expect_data;
        got         = 0;
        idle_cycles = 0;
        held        = 1'b0;
        held_data   = '0;
        t_ready_i   = !stall || ($urandom % 2 == 1);
        while (got < nbeats && !aborted) begin
            @(negedge clk);
            // A stalled beat must stay valid and unchanged
            if (held) begin
                check_value("t_valid_o", 64'(t_valid_o), 64'd1);
                check_value("t_data_o", t_data_o, held_data);
            end
            held = 1'b0;
            if (t_valid_o) begin
                idle_cycles = 0;
                if (t_ready_i) begin
                    for (int k = 0; k < 8; k++) begin
                        expect_data[8 * k +: 8] = exp_q[8 * got + k];
                    end
                    check_value("t_data_o", t_data_o, expect_data);
                    check_value("t_keep_o", 64'(t_keep_o), 64'hFF);
                    check_value("t_last_o", 64'(t_last_o), 64'(sha3 && got == nbeats - 1));
                    got++;
                end else begin
                    held      = 1'b1;
                    held_data = t_data_o;
                end
            end else begin
                idle_cycles++;
            end
            @(posedge clk);
            #1;
            t_ready_i = (got < nbeats) && (!stall || ($urandom % 2 == 1));
            if (idle_cycles > WAIT_LIMIT) begin
                $display("timeout at %0t, output beat %0d never became valid", $time, got);
                errors++;
                aborted = 1'b1;
            end
        end
        t_ready_i = 1'b0;
    endtask

    // SHAKE ends on stop, valid low in that cycle and after
    task automatic stop_output();
        stop_i    = 1'b1;
        t_ready_i = 1'b0;
        @(negedge clk);
        check_value("t_valid_o", 64'(t_valid_o), 64'd0);
        @(posedge clk);
        #1;
        stop_i = 1'b0;
        @(negedge clk);
        check_value("t_valid_o", 64'(t_valid_o), 64'd0);
        @(posedge clk);
        #1;
    endtask

    // Random message of len bytes through the core and the model
    task automatic process_message(input keccak_mode_e mode, input int len, input int nbeats,
                                   input bit gaps, input bit stall);
        if (aborted) begin
            return;
        end
        msg_q.delete();
        for (int i = 0; i < len; i++) begin
            msg_q.push_back(8'($urandom));
        end
        if (mode == MODE_SHA3_256) begin
            sponge_model(136, 8'h06, 32);
        end else begin
            sponge_model(168, 8'h1F, 8 * nbeats);
        end
        start_message(mode);
        send_message(gaps);
        collect_output(nbeats, stall, mode == MODE_SHA3_256);
        if (mode == MODE_SHAKE128 && !aborted) begin
            stop_output();
        end
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic check_reset_and_empty();
        @(negedge clk);
        check_value("t_ready_o", 64'(t_ready_o), 64'd0);
        check_value("t_valid_o", 64'(t_valid_o), 64'd0);
        @(posedge clk);
        #1;
        // Single beat with no kept bytes and last set
        process_message(MODE_SHA3_256, 0, 4, 1'b0, 1'b0);
    endtask

    // Two blocks ending on a partial beat
    task automatic two_block_digest();
        process_message(MODE_SHA3_256, 203, 4, 1'b0, 1'b0);
    endtask

    // Block fills on the last beat, padding needs its own block
    task automatic exact_rate_digest();
        process_message(MODE_SHA3_256, 136, 4, 1'b0, 1'b0);
    endtask

    // 30 beats cross one 168-byte block, then a fresh start
    task automatic shake_stream_and_stop();
        process_message(MODE_SHAKE128, 50, 30, 1'b0, 1'b0);
        process_message(MODE_SHA3_256, 9, 4, 1'b0, 1'b0);
    endtask

    task automatic random_flow_control();
        process_message(MODE_SHA3_256, 300, 4, 1'b1, 1'b1);
        process_message(MODE_SHAKE128, 180, 25, 1'b1, 1'b1);
    endtask

    initial begin
        void'($urandom(32'h7094_be6e));
        clk       = 1'b0;
        rst       = 1'b1;
        start_i   = 1'b0;
        mode_i    = MODE_SHA3_256;
        stop_i    = 1'b0;
        t_data_i  = '0;
        t_keep_i  = '0;
        t_last_i  = 1'b0;
        t_valid_i = 1'b0;
        t_ready_i = 1'b0;
        errors    = 0;
        checks    = 0;
        aborted   = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        check_reset_and_empty();
        two_block_digest();
        exact_rate_digest();
        shake_stream_and_stop();
        random_flow_control();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
rtl/keccak_pkg.sv
rtl/keccak_step.sv
rtl/keccak_absorb.sv
rtl/keccak_sponge.sv
rtl/keccak_squeeze.sv
rtl/keccak_top.sv
test/tb_keccak.sv

//--- run.sh
#!/usr/bin/env bash
# Build the Keccak testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_keccak -f compile.f \
    && ./obj_dir/Vtb_keccak | tee /dev/stderr | grep -F "Result: PASSED" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
